// ==== y86Fetch.f ====
+incdir+design
+incdir+verification
design/y86IsaPkg.sv
design/fetchStatusPkg.sv
design/fetchBytesIf.sv
design/instrMem.sv
design/instrSplit.sv
design/instrAlign.sv
design/y86Fetch.sv
verification/y86FetchTb.sv

// ==== Makefile ====
# Verilator flow for the Y86-64 fetch stage
TOP_TB  = y86FetchTb
TOP_RTL = y86Fetch

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f y86Fetch.f --top-module $(TOP_RTL)

# $fatal in the testbench makes simv exit non-zero
sim:
	verilator --binary --timing --assert -f y86Fetch.f --top-module $(TOP_TB) -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir

// ==== verification/y86FetchTasks.svh ====
//------------------------------
// included inside y86FetchTb; drives and samples its signals
//------------------------------
`ifndef Y86_FETCH_TASKS_SVH
`define Y86_FETCH_TASKS_SVH

task automatic stopOnError(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
endtask

task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
        stopOnError($sformatf("mismatch at %0t: %s got %h expected %h",
                              $time, name, got, exp));
    end
endtask

task automatic loadByte(input word_t addr, input byte_t data);
    @(posedge clk);
    memWrEn   <= 1'b1;
    memWrAddr <= addr[`IMEM_ADDR_W-1:0];
    memWrData <= data;
    @(posedge clk);
    memWrEn   <= 1'b0; // byte written on this edge
endtask

// polls fetchDone at falling edges, gives up after DONE_TIMEOUT cycles
task automatic waitDone(output logic seen);
    seen = 1'b0;
    for (int n = 0; n < DONE_TIMEOUT && !seen; n++)
    begin
        @(negedge clk);
        seen = fetchDone;
    end
endtask

task automatic checkOut(input logic [3:0] eCode, input nibble_t eFun, input regId_t eRA,
                        input regId_t eRB, input word_t eValC, input word_t eValP,
                        input fetchStat_t eStat);
    checkEq("icode", 64'(icode), 64'(eCode));
    checkEq("ifun", 64'(ifun), 64'(eFun));
    checkEq("rA", 64'(rA), 64'(eRA));
    checkEq("rB", 64'(rB), 64'(eRB));
    checkEq("valC", valC, eValC);
    checkEq("valP", valP, eValP);
    checkEq("stat", 64'(stat), 64'(eStat));
    checkEq("halted", 64'(halted), 64'(eStat == STAT_HLT)); // only a halt sets it
endtask

task automatic fetchAt(input word_t addr, input logic [3:0] eCode, input nibble_t eFun,
                       input regId_t eRA, input regId_t eRB, input word_t eValC,
                       input word_t eValP, input fetchStat_t eStat);
    logic seen;
    @(posedge clk);
    pcValid <= 1'b1;
    pc      <= addr;
    @(posedge clk);
    pcValid <= 1'b0;
    waitDone(seen);
    if (!seen)
    begin
        stopOnError($sformatf("no fetchDone within %0d cycles for pc %0d", DONE_TIMEOUT, addr));
    end
    checkOut(eCode, eFun, eRA, eRB, eValC, eValP, eStat);
endtask

`endif

// ==== verification/y86FetchTb.sv ====
//------------------------------
// directed tests; memory is never reset, so tests reuse loaded bytes
//------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module y86FetchTb
    import y86IsaPkg::*;
    import fetchStatusPkg::*;
();
    localparam int DONE_TIMEOUT = 10; // cycles to wait for fetchDone

    logic                    clk;
    logic                    rst;
    logic                    pcValid;
    word_t                   pc;
    logic                    memWrEn;
    logic [`IMEM_ADDR_W-1:0] memWrAddr;
    byte_t                   memWrData;
    icode_t                  icode;
    nibble_t                 ifun;
    regId_t                  rA;
    regId_t                  rB;
    word_t                   valC;
    word_t                   valP;
    fetchStat_t              stat;
    logic                    halted;
    logic                    fetchDone;
    int                      seed = 32'h60dc_8bd3;

    y86Fetch u_dut (.*);

    `include "y86FetchTasks.svh"

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic resetDut();
        @(posedge clk);
        rst <= 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic testReset();
        @(negedge clk);
        checkEq("fetchDone", 64'(fetchDone), 64'd0);
        checkOut(4'h0, 4'h0, 4'h0, 4'h0, 64'd0, 64'd0, STAT_AOK);
    endtask

    task automatic testShortForms();
        loadByte(64'd16, 8'h10); // nop
        loadByte(64'd17, 8'h90); // ret
        loadByte(64'd18, 8'h62); // andq
        loadByte(64'd19, 8'h3A);
        fetchAt(64'd16, 4'h1, 4'h0, 4'hF, 4'hF, 64'd0, 64'd17, STAT_AOK);
        fetchAt(64'd17, 4'h9, 4'h0, 4'hF, 4'hF, 64'd0, 64'd18, STAT_AOK);
        fetchAt(64'd18, 4'h6, 4'h2, 4'h3, 4'hA, 64'd0, 64'd20, STAT_AOK);
    endtask

    task automatic testLongForms();
        logic [3:0] codes [5];
        word_t      value;
        word_t      base;
        word_t      skip;
        codes = '{4'h3, 4'h4, 4'h5, 4'h7, 4'h8};
        for (int i = 0; i < 5; i++)
        begin
            base  = 64'(32 + 16 * i);
            value = {$random(seed), $random(seed)};
            skip  = (i < 3) ? 64'd2 : 64'd1; // register byte moves the constant
            loadByte(base, {codes[i], 4'h0});
            loadByte(base + 64'd1, 8'h45);
            for (int k = 0; k < 8; k++)
            begin
                loadByte(base + skip + 64'(k), value[8*k +: 8]); // lowest byte first
            end
            fetchAt(base, codes[i], 4'h0, (i < 3) ? 4'h4 : 4'hF, (i < 3) ? 4'h5 : 4'hF,
                    value, (i < 3) ? base + 64'd10 : base + 64'd9, STAT_AOK);
        end
    endtask

    task automatic testIllegal();
        for (int c = 12; c < 16; c++)
        begin
            loadByte(64'(200 + c), {4'(c), 4'h0});
            fetchAt(64'(200 + c), 4'(c), 4'h0, 4'hF, 4'hF, 64'd0, 64'(201 + c), STAT_INS);
        end
        loadByte(64'd220, 8'h64); // opq with ifun 4
        loadByte(64'd221, 8'h12);
        fetchAt(64'd220, 4'h6, 4'h4, 4'h1, 4'h2, 64'd0, 64'd222, STAT_INS);
    endtask

    task automatic testBounds();
        loadByte(64'd1020, 8'h30);
        loadByte(64'd1021, 8'hF3);
        loadByte(64'd1022, 8'h11);
        loadByte(64'd1023, 8'h22);
        // constant bytes past the end read as zero
        fetchAt(64'd1020, 4'h3, 4'h0, 4'hF, 4'h3, 64'h2211, 64'd1030, STAT_ADR);
        loadByte(64'd1023, 8'h10);
        fetchAt(64'd1023, 4'h1, 4'h0, 4'hF, 4'hF, 64'd0, 64'd1024, STAT_AOK);
        fetchAt(64'd5000, 4'h0, 4'h0, 4'hF, 4'hF, 64'd0, 64'd5001, STAT_ADR);
    endtask

    // one fetch per cycle, each result one cycle behind its pc
    task automatic testBackToBack();
        word_t      addrs [3];
        word_t      nexts [3];
        logic [3:0] codes [3];
        nibble_t    funs [3];
        regId_t     regA [3];
        regId_t     regB [3];
        addrs = '{64'd16, 64'd17, 64'd18};
        nexts = '{64'd17, 64'd18, 64'd20};
        codes = '{4'h1, 4'h9, 4'h6};
        funs  = '{4'h0, 4'h0, 4'h2};
        regA  = '{4'hF, 4'hF, 4'h3};
        regB  = '{4'hF, 4'hF, 4'hA};
        @(posedge clk);
        pcValid <= 1'b1;
        pc      <= addrs[0];
        for (int i = 1; i <= 3; i++)
        begin
            @(posedge clk);
            if (i < 3)
            begin
                pc <= addrs[i];
            end
            else
            begin
                pcValid <= 1'b0;
            end
            @(negedge clk);
            checkEq("fetchDone", 64'(fetchDone), 64'd1);
            checkOut(codes[i-1], funs[i-1], regA[i-1], regB[i-1], 64'd0, nexts[i-1],
                     STAT_AOK);
        end
    endtask

    task automatic testHalt();
        logic seen;
        loadByte(64'd300, 8'h00);
        fetchAt(64'd300, 4'h0, 4'h0, 4'hF, 4'hF, 64'd0, 64'd301, STAT_HLT);
        @(posedge clk);
        pcValid <= 1'b1;
        pc      <= 64'd16;
        @(posedge clk);
        pcValid <= 1'b0;
        waitDone(seen);
        if (seen)
        begin
            stopOnError("fetchDone pulsed while the fetch stage was halted");
        end
        checkEq("halted", 64'(halted), 64'd1);
        resetDut();
        fetchAt(64'd16, 4'h1, 4'h0, 4'hF, 4'hF, 64'd0, 64'd17, STAT_AOK);
    endtask

    initial
    begin
        rst       = 1'b1;
        pcValid   = 1'b0;
        pc        = '0;
        memWrEn   = 1'b0;
        memWrAddr = '0;
        memWrData = '0;
        resetDut();
        testReset();
        testShortForms();
        testLongForms();
        testIllegal();
        testBounds();
        testBackToBack();
        testHalt();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/y86Fetch.sv ====
//------------------------------
// pc supplied externally; memory loaded via write port
//------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module y86Fetch
    import y86IsaPkg::*;
    import fetchStatusPkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    pcValid,
    input  word_t                   pc,
    input  logic                    memWrEn,
    input  logic [`IMEM_ADDR_W-1:0] memWrAddr,
    input  byte_t                   memWrData,
    output icode_t                  icode,
    output nibble_t                 ifun,
    output regId_t                  rA,
    output regId_t                  rB,
    output word_t                   valC,
    output word_t                   valP,
    output fetchStat_t              stat,
    output logic                    halted,
    output logic                    fetchDone
);
    fetchBytesIf fb (.clk(clk));

    instrMem uMem (
        .clk       (clk),
        .memWrEn   (memWrEn),
        .memWrAddr (memWrAddr),
        .memWrData (memWrData),
        .pcValid   (pcValid),
        .pc        (pc),
        .fb        (fb.memSide)
    );

    instrSplit uSplit (
        .fb (fb.splitSide)
    );

    instrAlign uAlign (
        .clk       (clk),
        .rst       (rst),
        .fb        (fb.alignSide),
        .icode     (icode),
        .ifun      (ifun),
        .rA        (rA),
        .rB        (rB),
        .valC      (valC),
        .valP      (valP),
        .stat      (stat),
        .halted    (halted),
        .fetchDone (fetchDone)
    );

endmodule

`default_nettype wire

// ==== design/instrAlign.sv ====
//------------------------------
// outputs registered one cycle after reqValid; hold otherwise
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module instrAlign
    import y86IsaPkg::*;
    import fetchStatusPkg::*;
(
    input  logic            clk,
    input  logic            rst,
    fetchBytesIf.alignSide  fb,
    output icode_t          icode,
    output nibble_t         ifun,
    output regId_t          rA,
    output regId_t          rB,
    output word_t           valC,
    output word_t           valP,
    output fetchStat_t      stat,
    output logic            halted,
    output logic            fetchDone
);
    haltState_t state;
    logic       fetchNow;
    regId_t     rANext;
    regId_t     rBNext;
    word_t      valCNext;
    word_t      valPNext;
    fetchStat_t statNext;

    assign fetchNow = fb.reqValid && (state == RUNNING); // pcValid ignored once halted
    assign rANext   = fb.needRegIds ? fb.instrBytes[1][7:4] : REG_NONE;
    assign rBNext   = fb.needRegIds ? fb.instrBytes[1][3:0] : REG_NONE;
    assign valPNext = fb.reqPc + word_t'(instrLen(fb.icode));

    always_comb
    begin
        valCNext = '0;
        if (fb.needValC)
        begin
            for (int k = 0; k < 8; k++) // little-endian, lowest byte first
            begin
                valCNext[8*k +: 8] = fb.needRegIds ? fb.instrBytes[k+2] : fb.instrBytes[k+1];
            end
        end
    end

    always_comb
    begin
        if (fb.memError)
            statNext = STAT_ADR;
        else if (!fb.instrValid)
            statNext = STAT_INS;
        else if (fb.icode == HALT)
            statNext = STAT_HLT;
        else
            statNext = STAT_AOK;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= RUNNING;
            fetchDone <= 1'b0;
            icode     <= HALT;
            ifun      <= '0;
            rA        <= '0;
            rB        <= '0;
            valC      <= '0;
            valP      <= '0;
            stat      <= STAT_AOK;
        end
        else
        begin
            fetchDone <= fetchNow;
            if (fetchNow)
            begin
                icode <= fb.icode;
                ifun  <= fb.ifun;
                rA    <= rANext;
                rB    <= rBNext;
                valC  <= valCNext;
                valP  <= valPNext; // reported even on ADR or INS
                stat  <= statNext;
                if (statNext == STAT_HLT)
                begin
                    state <= HALTED;
                end
            end
        end
    end

    assign halted = (state == HALTED);

    noFetchWhenHalted: assert property (@(posedge clk) disable iff (rst)
        halted |=> !fetchDone);

endmodule

`default_nettype wire

// ==== design/instrSplit.sv ====
//------------------------------
// purely combinational; clk only samples the check
//------------------------------
`timescale 1ns/10ps
`default_nettype none

module instrSplit
    import y86IsaPkg::*;
(
    fetchBytesIf.splitSide fb
);
    logic [3:0] rawCode;   // icode nibble before the enum cast
    logic       codeInRange;
    logic       ifunLegal;

    assign rawCode     = fb.instrBytes[0][7:4];
    assign codeInRange = rawCode <= 4'(POPQ);
    assign fb.icode    = icode_t'(rawCode);
    assign fb.ifun     = fb.instrBytes[0][3:0];

    always_comb
    begin
        ifunLegal     = (fb.ifun == 4'h0); // most classes take no function code
        fb.needRegIds = 1'b0;
        fb.needValC   = 1'b0;
        case (fb.icode)
            CMOVXX:
            begin
                ifunLegal     = (fb.ifun <= 4'd6);
                fb.needRegIds = 1'b1;
            end
            OPQ:
            begin
                ifunLegal     = (fb.ifun <= 4'd3); // add, sub, and, xor
                fb.needRegIds = 1'b1;
            end
            JXX:
            begin
                ifunLegal   = (fb.ifun <= 4'd6);
                fb.needValC = 1'b1;
            end
            IRMOVQ, RMMOVQ, MRMOVQ:
            begin
                fb.needRegIds = 1'b1;
                fb.needValC   = 1'b1;
            end
            PUSHQ, POPQ: fb.needRegIds = 1'b1;
            CALL:        fb.needValC   = 1'b1;
            default:
            begin
                // halt, nop, ret and unknown codes carry nothing
            end
        endcase
    end

    assign fb.instrValid = codeInRange && ifunLegal;

    // every legal code is a named member of icode_t
    validInEnum: assert property (@(posedge fb.clk)
        fb.instrValid |-> (fb.icode inside {HALT, NOP, CMOVXX, IRMOVQ, RMMOVQ, MRMOVQ,
                                            OPQ, JXX, CALL, RET, PUSHQ, POPQ}));

endmodule

`default_nettype wire

// ==== design/instrMem.sv ====
//------------------------------
// async read, sync write; bytes past the end read as zero
//------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

module instrMem
    import y86IsaPkg::*;
(
    input  logic                    clk,
    input  logic                    memWrEn,
    input  logic [`IMEM_ADDR_W-1:0] memWrAddr,
    input  byte_t                   memWrData,
    input  logic                    pcValid,
    input  word_t                   pc,
    fetchBytesIf.memSide            fb
);
    byte_t      mem [`IMEM_BYTES];
    word_t      byteAddr [`INSTR_MAX_BYTES];
    logic [3:0] needLen; // bytes the instruction at pc occupies

    always_ff @(posedge clk)
    begin
        if (memWrEn)
        begin
            mem[memWrAddr] <= memWrData;
        end
    end

    always_comb
    begin
        for (int i = 0; i < `INSTR_MAX_BYTES; i++)
        begin
            byteAddr[i] = pc + word_t'(i);
            if (byteAddr[i] < word_t'(`IMEM_BYTES))
            begin
                fb.instrBytes[i] = mem[byteAddr[i][`IMEM_ADDR_W-1:0]];
            end
            else
            begin
                fb.instrBytes[i] = '0; // outside memory
            end
        end
    end

    assign needLen     = instrLen(fb.instrBytes[0][7:4]);
    assign fb.memError = pc > (word_t'(`IMEM_BYTES) - word_t'(needLen)); // last byte past end
    assign fb.reqValid = pcValid;
    assign fb.reqPc    = pc;

    // a write with an unknown address would corrupt an unknown byte
    wrAddrKnown: assert property (@(posedge clk) memWrEn |-> !$isunknown(memWrAddr));

endmodule

`default_nettype wire

// ==== design/fetchBytesIf.sv ====
//------------------------------
// all signals combinational within the fetch cycle
//------------------------------
`timescale 1ns/10ps
`default_nettype none

`include "fetch_params.svh"

interface fetchBytesIf
    import y86IsaPkg::*;
(
    input logic clk // sampling clock for checks only
);
    byte_t   instrBytes [`INSTR_MAX_BYTES]; // window starting at reqPc
    logic    reqValid;
    logic    memError;
    word_t   reqPc;

    icode_t  icode;
    nibble_t ifun;
    logic    instrValid;
    logic    needRegIds;
    logic    needValC;

    modport memSide (output instrBytes, reqValid, memError, reqPc);

    modport splitSide (input clk, instrBytes,
                       output icode, ifun, instrValid, needRegIds, needValC);

    modport alignSide (input instrBytes, reqValid, memError, reqPc,
                       icode, ifun, instrValid, needRegIds, needValC);

endinterface

`default_nettype wire

// ==== design/fetchStatusPkg.sv ====
//------------------------------
// status order follows the Y86 stat codes
//------------------------------
`default_nettype none

package fetchStatusPkg;

    // ADR outranks INS, INS outranks HLT
    typedef enum logic [1:0] {
        STAT_AOK = 2'd0,
        STAT_HLT = 2'd1,
        STAT_ADR = 2'd2,
        STAT_INS = 2'd3
    } fetchStat_t;

    // halted is sticky until reset
    typedef enum logic {
        RUNNING = 1'b0,
        HALTED  = 1'b1
    } haltState_t;

endpackage

`default_nettype wire

// ==== design/y86IsaPkg.sv ====
//------------------------------
// Y86-64 encodings; unknown icodes count as one byte long
//------------------------------
`default_nettype none

`include "fetch_params.svh"

package y86IsaPkg;

    typedef logic [63:0] word_t;   // data and address word
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  nibble_t; // ifun field
    typedef logic [3:0]  regId_t;

    localparam regId_t REG_NONE = 4'hF; // no register operand

    typedef enum logic [3:0] {
        HALT   = 4'h0,
        NOP    = 4'h1,
        CMOVXX = 4'h2,
        IRMOVQ = 4'h3,
        RMMOVQ = 4'h4,
        MRMOVQ = 4'h5,
        OPQ    = 4'h6,
        JXX    = 4'h7,
        CALL   = 4'h8,
        RET    = 4'h9,
        PUSHQ  = 4'hA,
        POPQ   = 4'hB
    } icode_t;

    // encoded length in bytes from the icode nibble
    function automatic logic [3:0] instrLen(input logic [3:0] code);
        case (code)
            4'h2, 4'h6, 4'hA, 4'hB: instrLen = `LEN_REG_BYTE;
            4'h3, 4'h4, 4'h5:       instrLen = `LEN_REG_CONST;
            4'h7, 4'h8:             instrLen = `LEN_DEST_ONLY;
            default:                instrLen = `LEN_BYTE_ONLY; // also out of range
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== design/fetch_params.svh ====
//------------------------------
// IMEM_ADDR_W must cover IMEM_BYTES; lengths are in bytes
//------------------------------
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

`define IMEM_BYTES      1024 // program memory size
`define IMEM_ADDR_W     10
`define INSTR_MAX_BYTES 10   // longest encoding, read window size

// instruction lengths per class
`define LEN_BYTE_ONLY   4'd1 // halt, nop, ret
`define LEN_REG_BYTE    4'd2 // cmovxx, opq, pushq, popq
`define LEN_DEST_ONLY   4'd9 // jxx, call
`define LEN_REG_CONST   4'd10 // irmovq, rmmovq, mrmovq

`endif
